// ==== design/fadd_pkg.sv ====
package fadd_pkg;

	////////////////////////////////////////
	// format defaults, IEEE double
	////////////////////////////////////////
	localparam int DBL_EXP_W  = 11; // biased exponent field
	localparam int DBL_FRAC_W = 52; // stored fraction, hidden bit not included

	localparam int GRS_W = 3; // guard, round, sticky below the fraction lsb

	// operand capture edge to result edge
	localparam int PIPE_LAT = 4;

	////////////////////////////////////////
	// width helpers
	////////////////////////////////////////

	// working significand: hidden bit, fraction, grs
	function automatic int sig_w(input int frac_w);
		return frac_w + 1 + GRS_W;
	endfunction

	// adder result, one extra bit on top for the carry
	function automatic int sum_w(input int frac_w);
		return sig_w(frac_w) + 1;
	endfunction

	// lead zero count must reach sum_w itself (all-zero sum)
	function automatic int cnt_w(input int frac_w);
		return $clog2(sum_w(frac_w) + 1);
	endfunction

endpackage

// ==== design/fadd_ctl.sv ====
`timescale 1ns/1ps

module fadd_ctl #(
	parameter int EXP_W  = fadd_pkg::DBL_EXP_W,
	parameter int FRAC_W = fadd_pkg::DBL_FRAC_W
) (
	input  logic                               rclk,
	input  logic                               i_reset,
	input  logic                               i_valid,
	input  logic                               i_sub,
	input  logic [EXP_W+FRAC_W:0]              i_opa,
	input  logic [EXP_W+FRAC_W:0]              i_opb,
	input  logic [fadd_pkg::cnt_w(FRAC_W)-1:0] i_lead0,     // stage 3 normalize count
	input  logic [FRAC_W-1:0]                  i_frac,      // stage 4 rounded fraction
	input  logic                               i_rnd_cout,  // stage 4 rounding carry
	output logic [FRAC_W:0]                    o_big_sig,
	output logic [FRAC_W:0]                    o_small_sig,
	output logic [fadd_pkg::cnt_w(FRAC_W)-1:0] o_shr_cnt,
	output logic                               o_eff_sub,   // stage 2
	output logic [3:1]                         o_stage_valid,
	output logic                               o_valid,
	output logic [EXP_W+FRAC_W:0]              o_result
);
	import fadd_pkg::*;

	localparam int W     = EXP_W + FRAC_W + 1;
	localparam int SUM_W = sum_w(FRAC_W);
	localparam int CNT_W = cnt_w(FRAC_W);

	logic [4:0] vld; // bit n high while stage n holds an operation

	// stage 0, captured operands
	logic [W-1:0] opa_q;
	logic [W-1:0] opb_q;
	logic         sub_q;

	// stage 0 decode and compare
	logic              sign_a;
	logic              sign_b;
	logic [EXP_W-1:0]  exp_a;
	logic [EXP_W-1:0]  exp_b;
	logic [FRAC_W-1:0] frac_a;
	logic [FRAC_W-1:0] frac_b;
	logic              b_gt_a;
	logic [EXP_W-1:0]  exp_big;
	logic [EXP_W-1:0]  exp_small;
	logic [EXP_W-1:0]  exp_diff;

	// sign and exponent down the pipe
	logic             eff_sub1;
	logic             sign1;
	logic [EXP_W-1:0] exp1;
	logic             sign2;
	logic [EXP_W-1:0] exp2;
	logic             sign3;
	logic [EXP_W-1:0] exp3;
	logic [EXP_W-1:0] exp_norm;
	logic             sign4;
	logic [EXP_W-1:0] exp4;
	logic             zero4;
	logic [EXP_W-1:0] exp_out;

	////////////////////////////////////////
	// valid chain
	////////////////////////////////////////
	always_ff @(posedge rclk) begin
		if (i_reset) begin
			vld <= '0;
		end else begin
			vld <= {vld[3:0], i_valid};
		end
	end

	assign o_stage_valid = vld[3:1]; // load enables for align, sum, rnd
	assign o_valid       = vld[4];

	// operand capture on the load strobe
	always_ff @(posedge rclk) begin
		if (i_valid) begin
			opa_q <= i_opa;
			opb_q <= i_opb;
			sub_q <= i_sub;
		end
	end

	////////////////////////////////////////
	// magnitude compare and swap
	////////////////////////////////////////
	assign sign_a = opa_q[W-1];
	assign sign_b = opb_q[W-1] ^ sub_q; // subtract flips the second sign
	assign exp_a  = opa_q[W-2:FRAC_W];
	assign exp_b  = opb_q[W-2:FRAC_W];
	assign frac_a = opa_q[FRAC_W-1:0];
	assign frac_b = opb_q[FRAC_W-1:0];

	// ties go to a, sign of an exact zero is overridden later anyway
	assign b_gt_a = (exp_b > exp_a) || ((exp_b == exp_a) && (frac_b > frac_a));

	assign exp_big   = b_gt_a ? exp_b : exp_a;
	assign exp_small = b_gt_a ? exp_a : exp_b;
	assign exp_diff  = exp_big - exp_small; // never negative

	always_ff @(posedge rclk) begin
		if (vld[0]) begin
			o_big_sig   <= b_gt_a ? {1'b1, frac_b} : {1'b1, frac_a}; // hidden bit set
			o_small_sig <= b_gt_a ? {1'b1, frac_a} : {1'b1, frac_b};
			// beyond sum_w everything lands in sticky
			o_shr_cnt   <= (exp_diff >= SUM_W) ? CNT_W'(SUM_W) : CNT_W'(exp_diff);
			eff_sub1    <= sign_a ^ sign_b;
			sign1       <= b_gt_a ? sign_b : sign_a; // larger operand sets the sign
			exp1        <= exp_big;
		end
	end

	// stage 2
	always_ff @(posedge rclk) begin
		if (vld[1]) begin
			o_eff_sub <= eff_sub1;
			sign2     <= sign1;
			exp2      <= exp1;
		end
	end

	// stage 3
	always_ff @(posedge rclk) begin
		if (vld[2]) begin
			sign3 <= sign2;
			exp3  <= exp2;
		end
	end

	////////////////////////////////////////
	// exponent adjust and packing
	////////////////////////////////////////

	// lead0 of 1 means the sum kept the position of the larger hidden bit
	assign exp_norm = exp3 + EXP_W'(1) - EXP_W'(i_lead0);

	always_ff @(posedge rclk) begin
		if (vld[3]) begin
			sign4 <= sign3;
			exp4  <= exp_norm;
			zero4 <= (i_lead0 == CNT_W'(SUM_W)); // exact cancellation
		end
	end

	assign exp_out  = exp4 + EXP_W'(i_rnd_cout); // rounding overflow bumps exponent
	assign o_result = zero4 ? '0 : {sign4, exp_out, i_frac}; // cancellation gives +0

endmodule

// ==== design/fadd_frac_align.sv ====
`timescale 1ns/1ps

module fadd_frac_align #(
	parameter int FRAC_W = fadd_pkg::DBL_FRAC_W
) (
	input  logic                               rclk,
	input  logic                               i_valid,     // stage 1 valid
	input  logic [FRAC_W:0]                    i_big_sig,
	input  logic [FRAC_W:0]                    i_small_sig,
	input  logic [fadd_pkg::cnt_w(FRAC_W)-1:0] i_shr_cnt,
	output logic [fadd_pkg::sig_w(FRAC_W)-1:0] o_big,
	output logic [fadd_pkg::sig_w(FRAC_W)-1:0] o_small_shr
);
	import fadd_pkg::*;

	localparam int SIG_W = sig_w(FRAC_W);

	logic [SIG_W-1:0]   small_ext;  // smaller significand with grs appended
	logic [2*SIG_W-1:0] shr_wide;   // upper half result, lower half shifted out
	logic [SIG_W-1:0]   small_shr;
	logic               sticky;

	assign small_ext = {i_small_sig, {GRS_W{1'b0}}};

	// nothing drops off the bottom for counts below SIG_W
	assign shr_wide = {small_ext, {SIG_W{1'b0}}} >> i_shr_cnt;

	////////////////////////////////////////
	// right shift with sticky
	////////////////////////////////////////
	always_comb begin
		if (i_shr_cnt >= SIG_W) begin
			small_shr = '0;
			sticky    = |small_ext; // whole operand below the lsb
		end else begin
			small_shr = shr_wide[2*SIG_W-1:SIG_W];
			sticky    = |shr_wide[SIG_W-1:0];
		end
	end

	// stage 2 register
	always_ff @(posedge rclk) begin
		if (i_valid) begin
			o_big       <= {i_big_sig, {GRS_W{1'b0}}};
			o_small_shr <= {small_shr[SIG_W-1:1], small_shr[0] | sticky}; // sticky folds into lsb
		end
	end

endmodule

// ==== design/fadd_cnt_lead0.sv ====
`timescale 1ns/1ps

module fadd_cnt_lead0 #(
	parameter int FRAC_W = fadd_pkg::DBL_FRAC_W
) (
	input  logic [fadd_pkg::sum_w(FRAC_W)-1:0] i_din,
	output logic [fadd_pkg::cnt_w(FRAC_W)-1:0] o_lead0
);
	import fadd_pkg::*;

	localparam int SUM_W = sum_w(FRAC_W);
	localparam int LVL   = cnt_w(FRAC_W); // tree depth
	localparam int P     = 1 << LVL;      // padded width, power of two

	logic [P-1:0] din_pad;

	// zero padding below, so only an all-zero input reaches the root as zero
	assign din_pad = {i_din, {(P-SUM_W){1'b0}}};

	for (genvar l = 1; l <= LVL; l++) begin : g_lvl
		localparam int NODES = P >> l;
		logic [l-1:0] cnt [NODES]; // count within the node, valid when z is low
		logic         z   [NODES]; // node is all zero
		for (genvar k = 0; k < NODES; k++) begin : g_node
			if (l == 1) begin : g_leaf
				assign cnt[k] = ~din_pad[2*k+1];
				assign z[k]   = ~din_pad[2*k+1] & ~din_pad[2*k];
			end else begin : g_merge
				// upper half empty, count continues into the lower half
				assign cnt[k] = g_lvl[l-1].z[2*k+1] ? {1'b1, g_lvl[l-1].cnt[2*k]}
				                                    : {1'b0, g_lvl[l-1].cnt[2*k+1]};
				assign z[k]   = g_lvl[l-1].z[2*k+1] & g_lvl[l-1].z[2*k];
			end
		end
	end

	assign o_lead0 = g_lvl[LVL].z[0] ? LVL'(SUM_W) : g_lvl[LVL].cnt[0];

endmodule

// ==== design/fadd_frac_sum.sv ====
`timescale 1ns/1ps

module fadd_frac_sum #(
	parameter int FRAC_W = fadd_pkg::DBL_FRAC_W
) (
	input  logic                               rclk,
	input  logic                               i_valid,     // stage 2 valid
	input  logic [fadd_pkg::sig_w(FRAC_W)-1:0] i_big,
	input  logic [fadd_pkg::sig_w(FRAC_W)-1:0] i_small_shr,
	input  logic                               i_eff_sub,
	output logic [fadd_pkg::sum_w(FRAC_W)-1:0] o_sum,
	output logic [fadd_pkg::cnt_w(FRAC_W)-1:0] o_lead0
);
	import fadd_pkg::*;

	localparam int SUM_W = sum_w(FRAC_W);
	localparam int CNT_W = cnt_w(FRAC_W);

	logic [SUM_W-1:0] sum;
	logic [CNT_W-1:0] lead0;

	////////////////////////////////////////
	// main fraction adder
	////////////////////////////////////////
	always_comb begin
		if (i_eff_sub) begin
			sum = {1'b0, i_big} - {1'b0, i_small_shr}; // big >= small, no sign out
		end else begin
			sum = {1'b0, i_big} + {1'b0, i_small_shr}; // carry lands in the top bit
		end
	end

	fadd_cnt_lead0 #(
		.FRAC_W (FRAC_W)
	) u_lead0 (
		.i_din   (sum),
		.o_lead0 (lead0)
	);

	// stage 3 register
	always_ff @(posedge rclk) begin
		if (i_valid) begin
			o_sum   <= sum;
			o_lead0 <= lead0;
		end
	end

endmodule

// ==== design/fadd_frac_rnd.sv ====
`timescale 1ns/1ps

module fadd_frac_rnd #(
	parameter int FRAC_W = fadd_pkg::DBL_FRAC_W
) (
	input  logic                               rclk,
	input  logic                               i_valid,    // stage 3 valid
	input  logic [fadd_pkg::sum_w(FRAC_W)-1:0] i_sum,
	input  logic [fadd_pkg::cnt_w(FRAC_W)-1:0] i_lead0,
	output logic [FRAC_W-1:0]                  o_frac,     // hidden bit dropped
	output logic                               o_rnd_cout
);
	import fadd_pkg::*;

	localparam int SUM_W    = sum_w(FRAC_W);
	localparam int FRAC_LSB = GRS_W + 1; // fraction lsb position after normalizing

	logic [SUM_W-1:0]  norm;
	logic [FRAC_W-1:0] frac_pre;  // fraction before rounding
	logic              lsb;
	logic              guard;
	logic              rest;      // round and sticky together
	logic              rnd_up;
	logic [FRAC_W:0]   rnd_add;   // carry out on top

	////////////////////////////////////////
	// post-normalization left shift
	////////////////////////////////////////

	// leading one moves to SUM_W-1, a zero sum stays zero
	assign norm = i_sum << i_lead0;

	assign frac_pre = norm[SUM_W-2:FRAC_LSB];
	assign lsb      = norm[FRAC_LSB];
	assign guard    = norm[FRAC_LSB-1];
	assign rest     = |norm[FRAC_LSB-2:0];

	////////////////////////////////////////
	// round to nearest even
	////////////////////////////////////////

	// above half rounds up, exact half only when the lsb is odd
	assign rnd_up = guard & (rest | lsb);

	// all-ones fraction plus one wraps to zero and sets the carry
	assign rnd_add = {1'b0, frac_pre} + (FRAC_W+1)'(rnd_up);

	// stage 4 register
	always_ff @(posedge rclk) begin
		if (i_valid) begin
			o_frac     <= rnd_add[FRAC_W-1:0];
			o_rnd_cout <= rnd_add[FRAC_W]; // exponent takes the increment
		end
	end

endmodule

// ==== design/fadd_top.sv ====
`timescale 1ns/1ps

module fadd_top #(
	parameter int EXP_W  = fadd_pkg::DBL_EXP_W,
	parameter int FRAC_W = fadd_pkg::DBL_FRAC_W
) (
	input  logic                  rclk,
	input  logic                  i_reset,
	input  logic                  i_valid,   // one operation per strobe
	input  logic                  i_sub,     // high for opa - opb
	input  logic [EXP_W+FRAC_W:0] i_opa,
	input  logic [EXP_W+FRAC_W:0] i_opb,
	output logic                  o_valid,
	output logic [EXP_W+FRAC_W:0] o_result
);
	import fadd_pkg::*;

	localparam int SIG_W = sig_w(FRAC_W);
	localparam int SUM_W = sum_w(FRAC_W);
	localparam int CNT_W = cnt_w(FRAC_W);

	// ctl to align
	logic [FRAC_W:0]   big_sig;
	logic [FRAC_W:0]   small_sig;
	logic [CNT_W-1:0]  shr_cnt;
	logic [3:1]        stage_valid;
	logic              eff_sub;
	// align to sum
	logic [SIG_W-1:0]  big;
	logic [SIG_W-1:0]  small_shr;
	// sum to rnd and ctl
	logic [SUM_W-1:0]  sum;
	logic [CNT_W-1:0]  lead0;
	// rnd to ctl
	logic [FRAC_W-1:0] frac;
	logic              rnd_cout;

	fadd_ctl #(
		.EXP_W  (EXP_W),
		.FRAC_W (FRAC_W)
	) u_ctl (
		.rclk          (rclk),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_sub         (i_sub),
		.i_opa         (i_opa),
		.i_opb         (i_opb),
		.i_lead0       (lead0),
		.i_frac        (frac),
		.i_rnd_cout    (rnd_cout),
		.o_big_sig     (big_sig),
		.o_small_sig   (small_sig),
		.o_shr_cnt     (shr_cnt),
		.o_eff_sub     (eff_sub),
		.o_stage_valid (stage_valid),
		.o_valid       (o_valid),
		.o_result      (o_result)
	);

	fadd_frac_align #(.FRAC_W(FRAC_W)) u_align (
		.rclk        (rclk),
		.i_valid     (stage_valid[1]),
		.i_big_sig   (big_sig),
		.i_small_sig (small_sig),
		.i_shr_cnt   (shr_cnt),
		.o_big       (big),
		.o_small_shr (small_shr)
	);

	fadd_frac_sum #(.FRAC_W(FRAC_W)) u_sum (
		.rclk        (rclk),
		.i_valid     (stage_valid[2]),
		.i_big       (big),
		.i_small_shr (small_shr),
		.i_eff_sub   (eff_sub),
		.o_sum       (sum),
		.o_lead0     (lead0)
	);

	fadd_frac_rnd #(.FRAC_W(FRAC_W)) u_rnd (
		.rclk       (rclk),
		.i_valid    (stage_valid[3]),
		.i_sum      (sum),
		.i_lead0    (lead0),
		.o_frac     (frac),
		.o_rnd_cout (rnd_cout)
	);

endmodule

// ==== tests/fadd_chk.sv ====
`timescale 1ns/1ps

module fadd_chk #(
	parameter int EXP_W  = fadd_pkg::DBL_EXP_W,
	parameter int FRAC_W = fadd_pkg::DBL_FRAC_W
) (
	input logic                  rclk,
	input logic                  i_reset,
	input logic                  i_valid,
	input logic                  o_valid,
	input logic [EXP_W+FRAC_W:0] o_result
);
	import fadd_pkg::*;

	////////////////////////////////////////
	// output strobe
	////////////////////////////////////////
	a_reset_quiet: assert property (@(posedge rclk) i_reset |=> !o_valid)
		else $error("o_valid high in the cycle after reset");

	// strobe sampled at edge N is seen high when sampled at edge N+PIPE_LAT+1
	a_latency: assert property (@(posedge rclk) disable iff (i_reset)
		o_valid == $past(i_valid, PIPE_LAT + 1))
		else $error("o_valid does not follow i_valid by the pipeline latency");

	// in-range operands never reach inf or nan
	a_exp_finite: assert property (@(posedge rclk) disable iff (i_reset)
		o_valid |-> (o_result[EXP_W+FRAC_W-1:FRAC_W] != '1))
		else $error("valid result with an all-ones exponent");

endmodule

bind fadd_ctl fadd_chk #(.EXP_W(EXP_W), .FRAC_W(FRAC_W)) u_chk (
	.rclk     (rclk),
	.i_reset  (i_reset),
	.i_valid  (i_valid),
	.o_valid  (o_valid),
	.o_result (o_result)
);

// ==== tests/tb_fadd.sv ====
`timescale 1ns/1ps

module tb_fadd;
	import fadd_pkg::*;

	localparam int N_ADD    = 400;
	localparam int N_SUB    = 400;
	localparam int N_CANCEL = 8;
	localparam int N_RND    = 3;
	localparam int N_STREAM = 64;
	localparam int N_TOTAL  = N_ADD + N_SUB + N_CANCEL + N_RND + N_STREAM;
	localparam logic [31:0] SEED = 32'h8b780035;

	logic        rclk = 1'b0;
	logic        i_reset;
	logic        i_valid;
	logic        i_sub;
	logic [63:0] i_opa;
	logic [63:0] i_opb;
	logic        o_valid;
	logic [63:0] o_result;

	int          cyc = 0;       // rising edges so far
	int          err_cnt = 0;   // value mismatches
	int          proto_cnt = 0; // strobe and drain problems
	string       cur_test = "reset";
	logic [63:0] exp_q[$];      // expected results in issue order
	int          edge_q[$];     // capture edge of each operation
	string       name_q[$];

	fadd_top #(.EXP_W(DBL_EXP_W), .FRAC_W(DBL_FRAC_W)) dut0 (
		.rclk     (rclk),
		.i_reset  (i_reset),
		.i_valid  (i_valid),
		.i_sub    (i_sub),
		.i_opa    (i_opa),
		.i_opb    (i_opb),
		.o_valid  (o_valid),
		.o_result (o_result)
	);

	always #5 rclk = ~rclk; // 10 ns period

	always @(posedge rclk) cyc <= cyc + 1;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	task automatic check_val(input string name, input logic [63:0] expv, input logic [63:0] actv);
		if (expv !== actv) begin
			$display("ERR %s exp %h act %h", name, expv, actv);
			err_cnt++;
		end
	endtask

	// reference model on simulator reals, which round to nearest even
	function automatic logic [63:0] model(input logic [63:0] a, input logic [63:0] b,
	                                      input logic sub);
		real ra;
		real rb;
		ra = $bitstoreal(a);
		rb = $bitstoreal(b);
		return $realtobits(sub ? ra - rb : ra + rb);
	endfunction

	// exponent kept in 0x300..0x4ff, far from overflow and denormals
	function automatic logic [63:0] rand_op();
		logic [10:0] e;
		logic [51:0] f;
		e = 11'h300 + 11'($urandom % 32'h200);
		f = 52'({$urandom, $urandom});
		return {1'($urandom), e, f};
	endfunction

	// same sign and exponent with the upper fraction bits shared
	function automatic logic [63:0] near_op(input logic [63:0] a);
		int          k;
		logic [51:0] m;
		k = $urandom % 52 + 1;
		m = (52'(1) << k) - 52'(1); // low k bits re-randomized
		return {a[63:52], (a[51:0] & ~m) | (52'({$urandom, $urandom}) & m)};
	endfunction

	task automatic drive_op(input logic [63:0] a, input logic [63:0] b, input logic sub);
		@(posedge rclk);
		i_valid <= 1'b1;
		i_opa   <= a;
		i_opb   <= b;
		i_sub   <= sub;
	endtask

	task automatic idle_cycle();
		@(posedge rclk);
		i_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		idle_cycle();
		while (exp_q.size() != 0 && n < PIPE_LAT + 10) begin
			@(posedge rclk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%s: %0d results still missing after the pipe drained", cur_test,
			         exp_q.size());
			proto_cnt++;
			exp_q.delete();
			edge_q.delete();
			name_q.delete();
		end
	endtask

	////////////////////////////////////////
	// monitor samples mid-cycle
	////////////////////////////////////////
	always @(negedge rclk) begin
		if (i_reset) check_val("reset_quiet", 64'd0, 64'(o_valid));
		if (o_valid) begin
			if (exp_q.size() == 0) begin
				$display("o_valid at edge %0d with no operation pending", cyc);
				proto_cnt++;
			end else begin
				check_val(name_q[0], exp_q.pop_front(), o_result);
				check_val({name_q.pop_front(), "_latency"}, 64'(edge_q.pop_front() + PIPE_LAT),
				          64'(cyc));
			end
		end
		if (i_valid && !i_reset) begin // taken at the next rising edge
			exp_q.push_back(model(i_opa, i_opb, i_sub));
			edge_q.push_back(cyc + 1);
			name_q.push_back(cur_test);
		end
	end

	// watchdog at twice the nominal run length
	initial begin
		#((N_TOTAL + PIPE_LAT + 20) * 10 * 2);
		$display("watchdog expired in %s, the run did not finish in time", cur_test);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	initial begin
		logic [63:0] a;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_sub   = 1'b0;
		i_opa   = '0;
		i_opb   = '0;
		void'($urandom(SEED));
		repeat (8) @(posedge rclk);
		i_reset <= 1'b0;
		repeat (3) @(posedge rclk);
		cur_test = "rand_add";
		for (int i = 0; i < N_ADD; i++) begin
			drive_op(rand_op(), rand_op(), 1'b0);
			if ($urandom % 4 == 0) idle_cycle(); // occasional gap
		end
		wait_drain();
		cur_test = "rand_sub";
		for (int i = 0; i < N_SUB; i++) begin
			a = rand_op();
			drive_op(a, (i % 2) ? near_op(a) : rand_op(), 1'b1); // odd ones cancel deeply
			if ($urandom % 4 == 0) idle_cycle();
		end
		wait_drain();
		cur_test = "exact_cancel";
		for (int i = 0; i < N_CANCEL; i++) begin
			a = rand_op();
			if (i < N_CANCEL / 2) drive_op(a, a, 1'b1);
			else drive_op(a, {~a[63], a[62:0]}, 1'b0); // plus its negation
		end
		wait_drain();
		cur_test = "round_tie";
		drive_op(64'h3FF0000000000000, 64'h3CA0000000000000, 1'b0); // tie stays even
		drive_op(64'h3FF0000000000001, 64'h3CA0000000000000, 1'b0); // tie with odd lsb rounds up
		drive_op(64'h3FFFFFFFFFFFFFFF, 64'h3CA0000000000000, 1'b0); // carry into exponent
		wait_drain();
		cur_test = "stream";
		for (int i = 0; i < N_STREAM; i++) drive_op(rand_op(), rand_op(), 1'($urandom));
		wait_drain();
		$display("summary: %0d value errors, %0d other errors", err_cnt, proto_cnt);
		if (err_cnt == 0 && proto_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
design/fadd_pkg.sv
design/fadd_ctl.sv
design/fadd_frac_align.sv
design/fadd_cnt_lead0.sv
design/fadd_frac_sum.sv
design/fadd_frac_rnd.sv
design/fadd_top.sv
tests/fadd_chk.sv
tests/tb_fadd.sv
